// ==== dv/sio_subsys_sva.sv ====
`timescale 1ns/1ns
`default_nettype none

// pin protocol and reset state of the output unit

module sio_subsys_sva (
    input wire                             clk,
    input wire                             rst,
    input wire serial_link_pkg::sio_pins_t pins,
    input wire                             obe,
    input wire                             sadd_q   // address bit ahead of the obe gate
);

    // data and address move only together with a rising ock
    a_shift_on_ock: assert property (@(posedge clk) disable iff (rst)
        ($changed(pins.sio_do) || $changed(pins.sadd)) |-> $rose(pins.ock))
        else $error("sio_do or sadd changed without a rising ock");

    a_reset_idle: assert property (@(posedge clk)
        rst |-> (obe && pins.sio_old))   // buffer empty, old high
        else $error("obe or sio_old low during reset");

    // address shifter already clear between frames, gate or no gate
    a_sadd_quiet: assert property (@(posedge clk) disable iff (rst)
        obe |-> !sadd_q)
        else $error("address bit high while obe is high");

endmodule

bind sio_out_unit sio_subsys_sva u_sva (
    .clk    (clk),
    .rst    (rst),
    .pins   (pins),
    .obe    (obe),
    .sadd_q (sadd_q)
);

`default_nettype wire

// ==== dv/sio_subsys_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

// testbench for the sio subsystem
// table driven with register writes read back and sdx frames checked at the receiver

module sio_subsys_tb;
    import dsp16_sio_pkg::*;
    import serial_link_pkg::*;

    localparam int N_ENTRY   = 16;
    localparam int CYC_LIMIT = N_ENTRY * 260 + 200;   // a frame takes about 210 clk
    localparam logic [1:0] SRC_IMM = 2'd0;
    localparam logic [1:0] SRC_ACC = 2'd1;
    localparam logic [1:0] SRC_RAM = 2'd2;

    typedef struct packed {
        logic        frame;      // 1 sdx frame, 0 register write
        logic [1:0]  src;        // source that carries the data
        logic        stack;      // lower priority strobes set as well
        logic [2:0]  rf;
        logic [15:0] data;
        logic [15:0] exp_rb;     // readback after a write
        logic [15:0] exp_data;   // receiver word after a frame
        logic [7:0]  exp_addr;
    } entry_t;

    logic        clk = 1'b0;
    logic        rst;
    sio_wr_t     cpu_wr;
    sio_pins_t   pins;
    logic        obe;
    logic [15:0] r_sio;
    rx_frame_t   rx_frame;
    logic        rx_valid;

    entry_t      tbl [N_ENTRY];
    int          cycle_cnt   = 0;
    int          rx_cnt      = 0;   // rx_valid pulses seen
    int          frames_sent = 0;
    int          entry_errs  = 0;
    int          pass_cnt    = 0;
    int          fail_cnt    = 0;
    logic [15:0] shadow_sioc = 16'h0000;   // expected readback of sioc
    logic [15:0] shadow_srta = 16'h0000;

    sio_subsys_top u_dut (
        .clk      (clk),
        .rst      (rst),
        .cpu_wr   (cpu_wr),
        .pins     (pins),
        .obe      (obe),
        .r_sio    (r_sio),
        .rx_frame (rx_frame),
        .rx_valid (rx_valid)
    );

    initial begin
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        if (rx_valid)
            rx_cnt = rx_cnt + 1;   // one per clk of the pulse
    end

    // run limit
    initial begin
        while (cycle_cnt < CYC_LIMIT) begin
            @(posedge clk);
            cycle_cnt = cycle_cnt + 1;
        end
        $display("timeout after %0d clk cycles, rx_valid never arrived", CYC_LIMIT);
        $display("Finished with errors");
        $finish;
    end

    function automatic entry_t make_entry(input logic frame, input logic [1:0] src,
                                          input logic stack, input logic [2:0] rf,
                                          input logic [15:0] data, input logic [15:0] exp_rb,
                                          input logic [15:0] exp_data,
                                          input logic [7:0] exp_addr);
        entry_t e;
        e = '{frame, src, stack, rf, data, exp_rb, exp_data, exp_addr};
        return e;
    endfunction

    task automatic fill_table();
        tbl[0]  = make_entry(1'b0, SRC_IMM, 1'b0, RF_SIOC, 16'hffff, 16'h03ff, 16'h0, 8'h0);
        tbl[1]  = make_entry(1'b0, SRC_ACC, 1'b0, RF_SRTA, 16'hffff, 16'h00ff, 16'h0, 8'h0);
        tbl[2]  = make_entry(1'b0, SRC_RAM, 1'b0, RF_SIOC, {6'h2a, SIOC_FIXED},
                             {6'd0, SIOC_FIXED}, 16'h0, 8'h0);
        tbl[3]  = make_entry(1'b0, SRC_RAM, 1'b0, RF_SRTA, 16'h12a5, 16'h00a5, 16'h0, 8'h0);
        tbl[4]  = make_entry(1'b0, SRC_IMM, 1'b1, RF_SRTA, 16'h3c5a, 16'h005a, 16'h0, 8'h0);
        tbl[5]  = make_entry(1'b0, SRC_ACC, 1'b1, RF_SRTA, 16'h7e81, 16'h0081, 16'h0, 8'h0);
        tbl[6]  = make_entry(1'b1, SRC_IMM, 1'b0, RF_SDX, 16'hffff, 16'h0, 16'hffff, 8'h81);
        tbl[7]  = make_entry(1'b0, SRC_ACC, 1'b0, RF_SRTA, 16'h00c3, 16'h00c3, 16'h0, 8'h0);
        tbl[8]  = make_entry(1'b1, SRC_ACC, 1'b0, RF_SDX, 16'h0000, 16'h0, 16'h0000, 8'hc3);
        tbl[9]  = make_entry(1'b0, SRC_RAM, 1'b0, RF_SRTA, 16'hff55, 16'h0055, 16'h0, 8'h0);
        tbl[10] = make_entry(1'b1, SRC_RAM, 1'b0, RF_SDX, 16'haaaa, 16'h0, 16'haaaa, 8'h55);
        tbl[11] = make_entry(1'b0, SRC_IMM, 1'b1, RF_SRTA, 16'h00aa, 16'h00aa, 16'h0, 8'h0);
        tbl[12] = make_entry(1'b1, SRC_IMM, 1'b1, RF_SDX, 16'h5555, 16'h0, 16'h5555, 8'haa);
        tbl[13] = make_entry(1'b1, SRC_ACC, 1'b1, RF_SDX, 16'h9c31, 16'h0, 16'h9c31, 8'haa);
        tbl[14] = make_entry(1'b0, SRC_IMM, 1'b0, 3'd3, 16'hbeef, 16'h0000, 16'h0, 8'h0);
        tbl[15] = make_entry(1'b0, SRC_ACC, 1'b1, RF_SIOC, 16'h0000, 16'h0000, 16'h0, 8'h0);
    endtask

    task automatic flag_mismatch(input string msg);
        $display("[ERROR] %0t ns: %s", $time, msg);
        entry_errs++;
    endtask

    task automatic tally(input string name);
        if (entry_errs == 0) begin
            pass_cnt++;
            $display("%s: ok", name);
        end else begin
            fail_cnt++;
            $display("%s: %0d error(s)", name, entry_errs);
        end
    endtask

    // random words on every source and the entry's word on its own source
    task automatic drive_load(input entry_t e);
        cpu_wr.long_imm = 16'($urandom);
        cpu_wr.acc_dout = 16'($urandom);
        cpu_wr.ram_dout = 16'($urandom);
        cpu_wr.r_field  = e.rf;
        cpu_wr.imm_load = (e.src == SRC_IMM);
        cpu_wr.acc_load = (e.src == SRC_ACC) || (e.stack && (e.src == SRC_IMM));
        cpu_wr.ram_load = (e.src == SRC_RAM) || e.stack;
        case (e.src)
            SRC_IMM: cpu_wr.long_imm = e.data;
            SRC_ACC: cpu_wr.acc_dout = e.data;
            default: cpu_wr.ram_dout = e.data;
        endcase
        repeat (2) @(negedge clk);   // two clk hold exactly one ph1 edge
        cpu_wr.imm_load = 1'b0;
        cpu_wr.acc_load = 1'b0;
        cpu_wr.ram_load = 1'b0;
    endtask

    task automatic check_readback(input logic [2:0] rf, input logic [15:0] exp);
        cpu_wr.r_field = rf;
        @(negedge clk);   // r_sio settled a full cycle
        if (r_sio !== exp)
            flag_mismatch($sformatf("r_sio for r_field %0d is %h, expected %h", rf, r_sio, exp));
    endtask

    task automatic run_write(input entry_t e);
        int rx_before;
        int rf;
        rx_before = rx_cnt;
        drive_load(e);
        repeat (4) @(negedge clk);
        if (e.rf == RF_SIOC)
            shadow_sioc = e.exp_rb;
        if (e.rf == RF_SRTA)
            shadow_srta = e.exp_rb;
        check_readback(RF_SIOC, shadow_sioc);
        check_readback(RF_SRTA, shadow_srta);
        for (rf = 2; rf < 8; rf++)
            check_readback(3'(rf), 16'h0000);   // no readable register there
        if (obe !== 1'b1 || pins.sio_old !== 1'b1)
            flag_mismatch($sformatf("write moved the pins, obe %b old %b", obe, pins.sio_old));
        if (rx_cnt != rx_before)
            flag_mismatch("a register write produced a received frame");
    endtask

    task automatic run_frame(input entry_t e);
        int rx_before;
        rx_before = rx_cnt;
        drive_load(e);
        frames_sent++;
        if (obe !== 1'b0)
            flag_mismatch("obe is still high after the sdx load");
        while (rx_valid !== 1'b1)
            @(negedge clk);   // frame length depends on the ock phase at the load
        if (rx_frame.data !== e.exp_data)
            flag_mismatch($sformatf("rx data is %h, expected %h", rx_frame.data, e.exp_data));
        if (rx_frame.address !== e.exp_addr)
            flag_mismatch($sformatf("rx address is %h, expected %h",
                                    rx_frame.address, e.exp_addr));
        if (obe !== 1'b1)
            flag_mismatch("obe is low when rx_valid pulses");
        @(negedge clk);
        if (rx_cnt != rx_before + 1)
            flag_mismatch($sformatf("%0d rx_valid pulses for one frame", rx_cnt - rx_before));
    endtask

    initial begin
        entry_t e;
        int     i;
        void'($urandom(32'hb149_c0cb));
        rst    = 1'b1;
        cpu_wr = '0;
        fill_table();
        repeat (8) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        if (obe !== 1'b1 || pins.sio_old !== 1'b1 || pins.ock !== 1'b0 || rx_valid !== 1'b0)
            flag_mismatch($sformatf("reset state obe %b old %b ock %b rx_valid %b",
                                    obe, pins.sio_old, pins.ock, rx_valid));
        check_readback(RF_SIOC, 16'h0000);
        check_readback(RF_SRTA, 16'h0000);
        tally("reset state");
        for (i = 0; i < N_ENTRY; i++) begin
            e          = tbl[i];
            entry_errs = 0;
            if (e.frame)
                run_frame(e);
            else
                run_write(e);
            tally($sformatf("entry %0d %s r_field %0d", i, e.frame ? "frame" : "write", e.rf));
        end
        entry_errs = 0;
        if (rx_cnt != frames_sent)
            flag_mismatch($sformatf("%0d frames received for %0d sent", rx_cnt, frames_sent));
        tally("frame count");
        $display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
hw/dsp16_sio_pkg.sv
hw/serial_link_pkg.sv
hw/sio_phase_gen.sv
hw/sio_out_unit.sv
hw/sio_frame_rx.sv
hw/sio_subsys_top.sv
dv/sio_subsys_sva.sv
dv/sio_subsys_tb.sv

// ==== hw/dsp16_sio_pkg.sv ====
`default_nettype none

package dsp16_sio_pkg;

    // r_field codes, same encoding for write select and readback
    localparam logic [2:0] RF_SIOC = 3'd0;  // serial i/o control
    localparam logic [2:0] RF_SRTA = 3'd1;  // serial address
    localparam logic [2:0] RF_SDX  = 3'd2;  // serial data out

    // only supported control word
    // 16-bit out, msb first, ock and old driven, ock = cki/12
    localparam logic [9:0] SIOC_FIXED = 10'h2e8;

    // ock divider, counted in ph1 ticks
    localparam logic [2:0] OCK_HALF   = 3'd2;  // count where ock rises
    localparam logic [2:0] OCK_PERIOD = 3'd6;  // ticks per ock period

    // cpu write bus into the sio
    typedef struct packed {
        logic        imm_load;   // long immediate source
        logic        acc_load;   // accumulator source
        logic        ram_load;   // data ram source
        logic [2:0]  r_field;    // target register
        logic [15:0] long_imm;
        logic [15:0] acc_dout;
        logic [15:0] ram_dout;
    } sio_wr_t;

    // write word as seen by sioc
    typedef struct packed {
        logic [5:0] unused;
        logic [9:0] sioc;
    } sioc_word_t;

    // write word as seen by srta
    typedef struct packed {
        logic [7:0] unused;
        logic [7:0] addr;        // channel address sent on sadd
    } srta_word_t;

    // one selected write word, decoded per r_field
    typedef union packed {
        sioc_word_t sioc_view;
        srta_word_t srta_view;
    } sio_load_u;

endpackage

`default_nettype wire

// ==== hw/serial_link_pkg.sv ====
`default_nettype none

package serial_link_pkg;

    localparam int FRAME_BITS = 16;  // data bits per frame
    localparam int ADDR_BITS  = 8;   // address bits, sent with the first data bits

    // bit counter width, must hold 0..FRAME_BITS
    localparam int BIT_CNT_W  = $clog2(FRAME_BITS + 1);

    // serial output pins
    typedef struct packed {
        logic ock;      // serial output clock
        logic sio_do;   // data, msb first
        logic sadd;     // address bit stream
        logic sio_old;  // output load, low during a frame
    } sio_pins_t;

    // rebuilt frame at the dac side
    typedef struct packed {
        logic [FRAME_BITS-1:0] data;
        logic [ADDR_BITS-1:0]  address;
    } rx_frame_t;

endpackage

`default_nettype wire

// ==== hw/sio_frame_rx.sv ====
`timescale 1ns/1ns
`default_nettype none

// dac side receiver
// arms on falling old, takes one bit per falling ock after each
// rising ock, rebuilds data and channel address

module sio_frame_rx (
    input  wire                            clk,
    input  wire                            rst,
    input  wire serial_link_pkg::sio_pins_t pins,
    output serial_link_pkg::rx_frame_t     rx_frame,
    output logic                           rx_valid   // one clk per frame
);
    import serial_link_pkg::*;

    logic                  ock_d;      // registered pin copies
    logic                  old_d;
    logic                  ock_rise;
    logic                  ock_fall;
    logic                  old_fall;
    logic                  armed;      // inside a frame
    logic                  bit_rdy;    // a fresh bit sits on the pins
    logic                  sample;
    logic                  last_bit;
    logic [BIT_CNT_W-1:0]  bit_cnt;
    logic [FRAME_BITS-1:0] data_sh;
    logic [FRAME_BITS-1:0] data_nxt;
    logic [ADDR_BITS-1:0]  addr_sh;

    assign ock_rise = pins.ock & ~ock_d;
    assign ock_fall = ~pins.ock & ock_d;
    assign old_fall = ~pins.sio_old & old_d;
    assign sample   = ock_fall & bit_rdy;
    assign last_bit = sample & (bit_cnt == BIT_CNT_W'(FRAME_BITS - 1));
    assign data_nxt = {data_sh[FRAME_BITS-2:0], pins.sio_do};   // msb first

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ock_d    <= 1'b0;
            old_d    <= 1'b1;
            armed    <= 1'b0;
            bit_rdy  <= 1'b0;
            bit_cnt  <= '0;
            rx_valid <= 1'b0;
        end else begin
            ock_d    <= pins.ock;
            old_d    <= pins.sio_old;
            rx_valid <= last_bit;
            if (old_fall) begin
                armed   <= 1'b1;   // the rise that dropped old carries no data
                bit_rdy <= 1'b0;
                bit_cnt <= '0;
            end else if (armed && ock_rise) begin
                bit_rdy <= 1'b1;
            end else if (sample) begin
                bit_rdy <= 1'b0;
                bit_cnt <= bit_cnt + 1'b1;
                if (last_bit)
                    armed <= 1'b0;
            end
        end
    end

    // payload, published together with rx_valid
    always_ff @(posedge clk) begin
        if (sample) begin
            data_sh <= data_nxt;
            if (bit_cnt < BIT_CNT_W'(ADDR_BITS))
                addr_sh <= {addr_sh[ADDR_BITS-2:0], pins.sadd};
        end
        if (last_bit) begin
            rx_frame.data    <= data_nxt;
            rx_frame.address <= addr_sh;   // complete since bit 7
        end
    end

endmodule

`default_nettype wire

// ==== hw/sio_out_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

// serial output unit, fixed configuration
// cpu writes sioc, srta or sdx; an sdx write sends one 16-bit frame
// msb first on sio_do with the srta address on sadd

module sio_out_unit (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        ph1,     // phase enable
    input  wire dsp16_sio_pkg::sio_wr_t cpu_wr,
    output serial_link_pkg::sio_pins_t pins,
    output logic                       obe,     // output buffer empty
    output logic [15:0]                r_sio    // register readback
);
    import dsp16_sio_pkg::*;
    import serial_link_pkg::*;

    logic [15:0]           sel_word;   // write word after source priority
    sio_load_u             load_w;
    logic                  any_load;
    logic                  sioc_load;
    logic                  srta_load;
    logic                  sdx_load;
    logic [9:0]            sioc;       // readback only
    logic [7:0]            srta;
    logic [2:0]            ph_cnt;     // ock divider
    logic                  ock_rise;
    logic                  ock_fall;
    logic                  shift_en;
    logic                  ock_q;
    logic                  sio_do_q;
    logic                  sadd_q;
    logic                  old_q;
    logic [FRAME_BITS:0]   ocnt;       // one-hot bit counter, top bit is obe
    logic [FRAME_BITS-1:0] data_sh;
    logic [ADDR_BITS-1:0]  addr_sh;

    // immediate over accumulator over ram
    assign any_load = cpu_wr.imm_load | cpu_wr.acc_load | cpu_wr.ram_load;
    assign sel_word = cpu_wr.imm_load ? cpu_wr.long_imm :
                      cpu_wr.acc_load ? cpu_wr.acc_dout : cpu_wr.ram_dout;
    assign load_w   = sio_load_u'(sel_word);

    assign sioc_load = any_load && (cpu_wr.r_field == RF_SIOC);
    assign srta_load = any_load && (cpu_wr.r_field == RF_SRTA);
    assign sdx_load  = any_load && (cpu_wr.r_field == RF_SDX);   // r_field 3+ ignored

    // divider decode, both act on the ph1 edge at that count
    assign ock_rise = (ph_cnt == OCK_HALF);
    assign ock_fall = (ph_cnt == OCK_PERIOD - 3'd1);

    // a data bit moves out on each rising ock once old is down
    assign shift_en = ph1 && ock_rise && !obe && !old_q && !sdx_load;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sioc <= '0;
            srta <= '0;
        end else if (ph1) begin
            if (sioc_load)
                sioc <= load_w.sioc_view.sioc;   // stored, config stays fixed
            if (srta_load)
                srta <= load_w.srta_view.addr;
        end
    end

    // ock: low for counts 0..2, high for 3..5
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ph_cnt <= '0;
            ock_q  <= 1'b0;
        end else if (ph1) begin
            ph_cnt <= ock_fall ? 3'd0 : ph_cnt + 3'd1;
            if (ock_rise)
                ock_q <= 1'b1;
            else if (ock_fall)
                ock_q <= 1'b0;
        end
    end

    // frame control
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ocnt     <= {1'b1, {FRAME_BITS{1'b0}}};  // empty
            old_q    <= 1'b1;
            sio_do_q <= 1'b0;
            sadd_q   <= 1'b0;
        end else if (ph1) begin
            if (sdx_load) begin
                ocnt   <= {{FRAME_BITS{1'b0}}, 1'b1};  // obe drops here
                sadd_q <= 1'b0;
            end else if (ock_rise && !obe) begin
                old_q <= 1'b0;   // first rise after load only lowers old
                if (!old_q) begin
                    sio_do_q <= data_sh[FRAME_BITS-1];
                    sadd_q   <= addr_sh[ADDR_BITS-1];
                    ocnt     <= ocnt << 1;  // reaches top bit with bit 15
                end
            end else if (obe) begin
                old_q <= 1'b1;   // frame done, raise old on next ph1
            end
        end
    end

    // payload shifters
    always_ff @(posedge clk) begin
        if (ph1 && sdx_load) begin
            data_sh <= sel_word;
            addr_sh <= srta;   // address snapshot at load time
        end else if (shift_en) begin
            data_sh <= data_sh << 1;
            addr_sh <= addr_sh << 1;   // zeros after the 8 address bits
        end
    end

    // readback, serial input registers read as zero
    always_comb begin
        case (cpu_wr.r_field)
            RF_SIOC: r_sio = {6'd0, sioc};
            RF_SRTA: r_sio = {8'd0, srta};
            default: r_sio = 16'd0;
        endcase
    end

    assign obe          = ocnt[FRAME_BITS];
    assign pins.ock     = ock_q;
    assign pins.sio_do  = sio_do_q;
    assign pins.sadd    = sadd_q & ~obe;   // quiet between frames
    assign pins.sio_old = old_q;

endmodule

`default_nettype wire

// ==== hw/sio_phase_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

// processor phase enable
// ph1 is a clock enable, high one clk out of two, so the
// sio and the rest of the dsp run at the phase rate

module sio_phase_gen (
    input  wire  clk,
    input  wire  rst,
    output logic ph1   // phase 1 enable
);

    // toggle flop, low in reset so the first enabled edge
    // comes one clk after reset release
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ph1 <= 1'b0;
        end else begin
            ph1 <= ~ph1;  // 50% duty enable
        end
    end

endmodule

`default_nettype wire

// ==== hw/sio_subsys_top.sv ====
`timescale 1ns/1ns
`default_nettype none

// sio subsystem: phase enable, output unit and a receiver
// standing in for the dac on the board

module sio_subsys_top (
    input  wire                            clk,
    input  wire                            rst,
    input  wire dsp16_sio_pkg::sio_wr_t    cpu_wr,     // cpu write bus
    output wire serial_link_pkg::sio_pins_t pins,      // serial pins
    output wire                            obe,
    output wire [15:0]                     r_sio,
    output wire serial_link_pkg::rx_frame_t rx_frame,
    output wire                            rx_valid
);

    wire ph1;   // processor phase enable

    sio_phase_gen u_phase (
        .clk (clk),
        .rst (rst),
        .ph1 (ph1)
    );

    sio_out_unit u_out (
        .clk    (clk),
        .rst    (rst),
        .ph1    (ph1),
        .cpu_wr (cpu_wr),
        .pins   (pins),
        .obe    (obe),
        .r_sio  (r_sio)
    );

    // runs on every clk, only watches the pins
    sio_frame_rx u_rx (
        .clk      (clk),
        .rst      (rst),
        .pins     (pins),
        .rx_frame (rx_frame),
        .rx_valid (rx_valid)
    );

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the sio subsystem testbench with verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module sio_subsys_tb -f filelist.f -o sim_sio

./obj_dir/sim_sio | tee sim.log

if grep -q "Finished with errors" sim.log; then
    echo "simulation failed, see sim.log"
    exit 1
fi
echo "simulation passed"
